//--- rc5_top.f
+incdir+include
logic/rc5_pkg.sv
logic/rc5_blk_if.sv
logic/rc5_key_sched.sv
logic/rc5_in_port.sv
logic/rc5_round_core.sv
logic/rc5_out_port.sv
logic/rc5_top.sv
verif/rc5_tb.sv

//--- verif/rc5_tests.txt
# each line holds a command, a 128-bit key, an input block and an expected block
# K loads the key, E encrypts and D decrypts; all hex is in byte-stream order
K 00000000000000000000000000000000 0000000000000000 0000000000000000
E 00000000000000000000000000000000 0000000000000000 21A5DBEE154B8F6D
D 00000000000000000000000000000000 21A5DBEE154B8F6D 0000000000000000
K 915F4619BE41B2516355A50110A9CE91 0000000000000000 0000000000000000
E 915F4619BE41B2516355A50110A9CE91 21A5DBEE154B8F6D F7C013AC5B2B8952
D 915F4619BE41B2516355A50110A9CE91 F7C013AC5B2B8952 21A5DBEE154B8F6D
K 783348E75AEB0F2FD7B169BB8DC16787 0000000000000000 0000000000000000
E 783348E75AEB0F2FD7B169BB8DC16787 F7C013AC5B2B8952 2F42B3B70369FC92
D 783348E75AEB0F2FD7B169BB8DC16787 2F42B3B70369FC92 F7C013AC5B2B8952
K DC49DB1375A5584F6485B413B5F12BAF 0000000000000000 0000000000000000
E DC49DB1375A5584F6485B413B5F12BAF 2F42B3B70369FC92 65C178B284D197CC
D DC49DB1375A5584F6485B413B5F12BAF 65C178B284D197CC 2F42B3B70369FC92
K 5269F149D41BA0152497574D7F153125 0000000000000000 0000000000000000
E 5269F149D41BA0152497574D7F153125 65C178B284D197CC EB44E415DA319824
D 5269F149D41BA0152497574D7F153125 EB44E415DA319824 65C178B284D197CC
K 00000000000000000000000000000000 0000000000000000 0000000000000000
D 00000000000000000000000000000000 21A5DBEE154B8F6D 0000000000000000
E 00000000000000000000000000000000 0000000000000000 21A5DBEE154B8F6D

//--- verif/rc5_tb.sv
`timescale 1ns/1ns

module rc5_tb;

	logic            i_clk = 1'b0;
	logic            i_rst, i_key_load, i_in_req, i_in_decrypt, i_out_ack;
	logic            o_key_ready, o_in_ack, o_out_req;
	rc5_pkg::ukey_t  i_key, rkey, key_rd;
	rc5_pkg::block_t i_in_data, o_out_data, in_rd, exp_rd, kat_got, stream_got;
	rc5_pkg::block_t in_q[$], exp_q[$], orig[64], mid[64], back[64];
	rc5_pkg::ukey_t  key_q[$];
	logic [7:0]      cmd_q[$], c;
	integer          seed, errors, fd, ch, limit, nkeys, i;
	bit              loaded, pair;

	rc5_top dut_i (.*);

	always #4 i_clk = ~i_clk;  // 8 ns period.

	always @(negedge i_clk) begin
		if (!i_rst && o_in_ack && !o_key_ready) begin
			errors++;
			$display("o_in_ack rose at %0t while the key schedule was still busy", $time);
		end
	end

	task pulse_key_load(input rc5_pkg::ukey_t k);
		@(posedge i_clk);
		i_key      <= k;
		i_key_load <= 1'b1;
		@(posedge i_clk);
		i_key_load <= 1'b0;
	endtask

	// called in the cycle after the load, which counts as cycle one.
	task time_key_load();
		int cycles;
		cycles = 1;
		@(negedge i_clk);
		while (!o_key_ready && cycles < 300) begin
			@(posedge i_clk);
			cycles++;
			@(negedge i_clk);
		end
		if (cycles != 105) begin
			errors++;
			$display("[FAIL] %0t o_key_ready latency expected %0d got %0d", $time, 105, cycles);
		end
	endtask

	task send_block(input rc5_pkg::block_t data, input bit dec);
		@(posedge i_clk);
		i_in_data    <= data;
		i_in_decrypt <= dec;
		i_in_req     <= 1'b1;
		do @(negedge i_clk); while (!o_in_ack);
		@(posedge i_clk);
		i_in_req <= 1'b0;
		do @(negedge i_clk); while (o_in_ack);
	endtask

	task recv_block(output rc5_pkg::block_t got, input int delay);
		do @(negedge i_clk); while (!o_out_req);
		got = o_out_data;
		repeat (delay) begin
			@(negedge i_clk);
			if (!o_out_req) begin
				errors++;
				$display("o_out_req dropped at %0t before it was acknowledged", $time);
			end
			if (o_out_data !== got) begin
				errors++;
				$display("[FAIL] %0t o_out_data expected %h got %h", $time, got, o_out_data);
			end
		end
		@(posedge i_clk);
		i_out_ack <= 1'b1;
		do @(negedge i_clk); while (o_out_req);
		@(posedge i_clk);
		i_out_ack <= 1'b0;
	endtask

	task run_vector(input int idx);
		fork
			send_block(in_q[idx], cmd_q[idx] == "D");
			recv_block(kat_got, 0);
		join
		if (kat_got !== exp_q[idx]) begin
			errors++;
			$display("[FAIL] %0t o_out_data expected %h got %h", $time, exp_q[idx], kat_got);
		end
	endtask

	// the consumer stalls each result by a random 0 to 20 cycles.
	task run_stream(input bit dec);
		fork
			for (int j = 0; j < 64; j++)
				send_block(dec ? mid[j] : orig[j], dec);
			for (int k = 0; k < 64; k++) begin
				recv_block(stream_got, {$random(seed)} % 21);
				if (dec)
					back[k] = stream_got;
				else
					mid[k] = stream_got;
			end
		join
	endtask

	// ########################################
	// watchdog
	// ########################################

	initial begin
		wait (loaded);
		repeat (limit) @(posedge i_clk);
		$display("timeout after %0d cycles with the run unfinished", limit);
		$display("errors: %0d", errors + 1);
		$display("Test failures found");
		$finish;
	end

	// ########################################
	// main sequence
	// ########################################

	initial begin
		{i_rst, i_key_load, i_in_req, i_in_decrypt, i_out_ack} = 5'b10000;
		i_key     = '0;
		i_in_data = '0;
		seed      = 12987;
		errors    = 0;
		nkeys     = 1;  // the random round-trip key.
		fd = $fopen("verif/rc5_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open verif/rc5_tests.txt");
		end else begin
			while ($fscanf(fd, " %c", c) == 1) begin
				if (c == "#") begin
					do ch = $fgetc(fd); while (ch != 10 && ch != -1);
				end else if ($fscanf(fd, " %h %h %h", key_rd, in_rd, exp_rd) == 3) begin
					cmd_q.push_back(c);
					key_q.push_back(key_rd);
					in_q.push_back(in_rd);
					exp_q.push_back(exp_rd);
					if (c == "K")
						nkeys++;
				end
			end
			$fclose(fd);
		end
		limit  = (cmd_q.size() - nkeys + 1 + 64) * 300 + nkeys * 200;
		loaded = 1'b1;
		repeat (4) @(posedge i_clk);
		i_rst <= 1'b0;
		@(negedge i_clk);
		if (o_in_ack || o_out_req || o_key_ready) begin
			errors++;
			$display("handshake or key ready outputs were not low after reset");
		end
		i = 0;
		while (i < cmd_q.size()) begin
			if (cmd_q[i] == "K") begin
				pair = (i + 1 < cmd_q.size()) && (cmd_q[i+1] != "K");
				pulse_key_load(key_q[i]);
				fork
					time_key_load();
					if (pair) run_vector(i + 1);  // request waits during the expansion.
				join
				i = pair ? i + 2 : i + 1;
			end else begin
				run_vector(i);
				i++;
			end
		end
		rkey = {$random(seed), $random(seed), $random(seed), $random(seed)};
		for (int j = 0; j < 64; j++)
			orig[j] = {$random(seed), $random(seed)};
		pulse_key_load(rkey);
		time_key_load();
		run_stream(1'b0);
		run_stream(1'b1);
		for (int j = 0; j < 64; j++) begin
			if (back[j] !== orig[j]) begin
				errors++;
				$display("[FAIL] %0t o_out_data expected %h got %h", $time, orig[j], back[j]);
			end
		end
		repeat (20) begin
			@(negedge i_clk);
			if (o_out_req) begin
				errors++;
				$display("an extra output block appeared at %0t", $time);
			end
		end
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- logic/rc5_top.sv
`timescale 1ns/1ns

module rc5_top (
	input  logic            i_clk,
	input  logic            i_rst,
	input  logic            i_key_load,
	input  rc5_pkg::ukey_t  i_key,
	output logic            o_key_ready,
	input  logic            i_in_req,
	output logic            o_in_ack,
	input  logic            i_in_decrypt,
	input  rc5_pkg::block_t i_in_data,
	output logic            o_out_req,
	input  logic            i_out_ack,
	output rc5_pkg::block_t o_out_data
);

	rc5_pkg::skey_t  skey;
	rc5_pkg::block_t core_result;
	logic            core_done;
	logic            out_full;

	rc5_blk_if blk ();

	// ########################################
	// input side
	// ########################################

	rc5_key_sched key_sched_i (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_load  (i_key_load),
		.i_key   (i_key),
		.o_skey  (skey),
		.o_ready (o_key_ready)
	);

	rc5_in_port in_port_i (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_req     (i_in_req),
		.i_decrypt (i_in_decrypt),
		.i_data    (i_in_data),
		.o_ack     (o_in_ack),
		.blk       (blk.src)
	);

	rc5_round_core round_core_i (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.blk         (blk.dst),
		.i_skey      (skey),
		.i_key_ready (o_key_ready),
		.i_out_full  (out_full),
		.o_done      (core_done),
		.o_result    (core_result)
	);

	rc5_out_port out_port_i (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_done   (core_done),
		.i_result (core_result),
		.o_full   (out_full),
		.o_req    (o_out_req),
		.o_data   (o_out_data),
		.i_ack    (i_out_ack)
	);

endmodule

//--- logic/rc5_out_port.sv
`timescale 1ns/1ns

module rc5_out_port (
	input  logic            i_clk,
	input  logic            i_rst,
	input  logic            i_done,
	input  rc5_pkg::block_t i_result,
	output logic            o_full,
	output logic            o_req,
	output rc5_pkg::block_t o_data,
	input  logic            i_ack
);

	rc5_pkg::tx_state_t state;
	logic               load;

	assign load = i_done && (state == rc5_pkg::EMPTY);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= rc5_pkg::EMPTY;
		end else begin
			case (state)
				rc5_pkg::EMPTY:        if (load) state <= rc5_pkg::REQ_HIGH;
				rc5_pkg::REQ_HIGH:     if (i_ack) state <= rc5_pkg::WAIT_ACK_LOW;
				rc5_pkg::WAIT_ACK_LOW: if (!i_ack) state <= rc5_pkg::EMPTY;  // buffer freed.
				default:               state <= rc5_pkg::EMPTY;
			endcase
		end
	end

	// held until the consumer has finished the handshake.
	always_ff @(posedge i_clk) begin
		if (load)
			o_data <= i_result;
	end

	assign o_req  = (state == rc5_pkg::REQ_HIGH);
	assign o_full = (state != rc5_pkg::EMPTY);

endmodule

//--- logic/rc5_round_core.sv
`timescale 1ns/1ns
`include "rc5_consts.svh"

module rc5_round_core (
	input  logic            i_clk,
	input  logic            i_rst,
	rc5_blk_if.dst          blk,
	input  rc5_pkg::skey_t  i_skey,
	input  logic            i_key_ready,
	input  logic            i_out_full,
	output logic            o_done,
	output rc5_pkg::block_t o_result
);

	localparam int W  = `RC5_W;
	localparam int KW = (`RC5_T - 4) * W;  // subkeys still needed after round 1.
	localparam int CW = $clog2(`RC5_R);

	logic [CW-1:0]   count;
	logic            start;
	logic            dec;
	logic            dec_r;
	rc5_pkg::block_t st_r;
	logic [KW-1:0]   key_r;
	rc5_pkg::word_t  a_in;
	rc5_pkg::word_t  b_in;
	rc5_pkg::word_t  a_sw;
	rc5_pkg::word_t  b_sw;
	rc5_pkg::word_t  ka;
	rc5_pkg::word_t  kb;
	rc5_pkg::word_t  a_out;
	rc5_pkg::word_t  b_out;
	rc5_pkg::word_t  s0;
	rc5_pkg::word_t  s1;

	function automatic rc5_pkg::word_t rol(input rc5_pkg::word_t x, input logic [4:0] s);
		logic [2*`RC5_W-1:0] d;
		d = {x, x} << s;
		return d[2*`RC5_W-1:`RC5_W];
	endfunction

	function automatic rc5_pkg::word_t bswap(input rc5_pkg::word_t x);
		return {x[7:0], x[15:8], x[23:16], x[31:24]};
	endfunction

	assign blk.ready = (count == '0) && !i_out_full && i_key_ready;
	assign start     = blk.valid && blk.ready;
	assign dec       = start ? blk.decrypt : dec_r;

	assign s0   = i_skey[0 +: W];
	assign s1   = i_skey[W +: W];
	assign a_sw = bswap(blk.data[2*W-1:W]);
	assign b_sw = bswap(blk.data[W-1:0]);

	// ########################################
	// round datapath
	// ########################################

	always_comb begin
		if (start) begin
			a_in = dec ? a_sw : a_sw + s0;  // pre-whitening only on encrypt.
			b_in = dec ? b_sw : b_sw + s1;
			ka   = dec ? i_skey[(`RC5_T-2)*W +: W] : i_skey[2*W +: W];
			kb   = dec ? i_skey[(`RC5_T-1)*W +: W] : i_skey[3*W +: W];
		end else begin
			a_in = st_r[2*W-1:W];
			b_in = st_r[W-1:0];
			ka   = dec ? key_r[KW-2*W +: W] : key_r[0 +: W];
			kb   = dec ? key_r[KW-W +: W] : key_r[W +: W];
		end
		if (dec) begin
			b_out = rol(b_in - kb, 5'd0 - a_in[4:0]) ^ a_in;  // rotate right by a.
			a_out = rol(a_in - ka, 5'd0 - b_out[4:0]) ^ b_out;
		end else begin
			a_out = rol(a_in ^ b_in, b_in[4:0]) + ka;
			b_out = rol(b_in ^ a_out, a_out[4:0]) + kb;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			count <= '0;
			dec_r <= 1'b0;
		end else begin
			if (start)
				count <= CW'(1);
			else if (count == CW'(`RC5_R - 1))
				count <= '0;
			else if (count != '0)
				count <= count + 1'b1;
			if (start)
				dec_r <= blk.decrypt;
		end
	end

	// encrypt walks the table upward, decrypt downward.
	always_ff @(posedge i_clk) begin
		st_r <= {a_out, b_out};
		if (start)
			key_r <= blk.decrypt ? i_skey[(`RC5_T-2)*W-1:2*W] : i_skey[`RC5_T*W-1:4*W];
		else if (count != '0)
			key_r <= dec ? {key_r[KW-2*W-1:0], {2*W{1'b0}}} : {{2*W{1'b0}}, key_r[KW-1:2*W]};
	end

	assign o_done   = (count == CW'(`RC5_R - 1));
	assign o_result = dec ? {bswap(a_out - s0), bswap(b_out - s1)} : {bswap(a_out), bswap(b_out)};

endmodule

//--- logic/rc5_in_port.sv
`timescale 1ns/1ns

module rc5_in_port (
	input  logic            i_clk,
	input  logic            i_rst,
	input  logic            i_req,
	input  logic            i_decrypt,
	input  rc5_pkg::block_t i_data,
	output logic            o_ack,
	rc5_blk_if.src          blk
);

	rc5_pkg::tx_state_t state;
	logic               hold;
	logic               take;

	// only accept when nothing is buffered and the core could start it.
	assign take = i_req && !hold && blk.ready && (state == rc5_pkg::WAIT_REQ);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= rc5_pkg::WAIT_REQ;
			hold  <= 1'b0;
		end else begin
			case (state)
				rc5_pkg::WAIT_REQ:  if (take) state <= rc5_pkg::ACKED;
				rc5_pkg::ACKED:     if (!i_req) state <= rc5_pkg::WAIT_DROP;
				rc5_pkg::WAIT_DROP: state <= rc5_pkg::WAIT_REQ;  // ack stays low one cycle.
				default:            state <= rc5_pkg::WAIT_REQ;
			endcase
			if (take)
				hold <= 1'b1;
			else if (blk.valid && blk.ready)
				hold <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (take) begin
			blk.data    <= i_data;
			blk.decrypt <= i_decrypt;
		end
	end

	assign blk.valid = hold;
	assign o_ack     = (state == rc5_pkg::ACKED);

endmodule

//--- logic/rc5_key_sched.sv
`timescale 1ns/1ns
`include "rc5_consts.svh"

module rc5_key_sched (
	input  logic           i_clk,
	input  logic           i_rst,
	input  logic           i_load,
	input  rc5_pkg::ukey_t i_key,
	output rc5_pkg::skey_t o_skey,
	output logic           o_ready
);

	localparam int C     = `RC5_KEY_BYTES / 4;  // key words in l.
	localparam int STEPS = 3 * `RC5_T;          // t is larger than c here.
	localparam int IW    = $clog2(`RC5_T);
	localparam int LW    = $clog2(C);
	localparam int SW    = $clog2(STEPS);

	rc5_pkg::ks_state_t state;
	rc5_pkg::word_t     s_tab [`RC5_T];
	rc5_pkg::word_t     l_arr [C];
	rc5_pkg::word_t     a_reg;
	rc5_pkg::word_t     b_reg;
	rc5_pkg::word_t     p_val;
	rc5_pkg::word_t     a_new;
	rc5_pkg::word_t     b_new;
	rc5_pkg::word_t     ab_sum;
	logic [IW-1:0]      s_idx;
	logic [LW-1:0]      l_idx;
	logic [SW-1:0]      step;

	function automatic rc5_pkg::word_t rol(input rc5_pkg::word_t x, input logic [4:0] s);
		logic [2*`RC5_W-1:0] d;
		d = {x, x} << s;
		return d[2*`RC5_W-1:`RC5_W];
	endfunction

	function automatic rc5_pkg::word_t bswap(input rc5_pkg::word_t x);
		return {x[7:0], x[15:8], x[23:16], x[31:24]};
	endfunction

	// ########################################
	// one mixing step
	// ########################################

	assign a_new  = rol(s_tab[s_idx] + a_reg + b_reg, 5'd3);
	assign ab_sum = a_new + b_reg;
	assign b_new  = rol(l_arr[l_idx] + ab_sum, ab_sum[4:0]);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= rc5_pkg::IDLE;
			s_idx <= '0;
			l_idx <= '0;
			step  <= '0;
			for (int k = 0; k < `RC5_T; k++)
				s_tab[k] <= '0;
		end else if (i_load) begin
			state <= rc5_pkg::INIT;  // a reload restarts from any state.
			s_idx <= '0;
			l_idx <= '0;
			step  <= '0;
		end else begin
			case (state)
				rc5_pkg::INIT: begin
					s_tab[s_idx] <= p_val;
					if (s_idx == IW'(`RC5_T - 1)) begin
						s_idx <= '0;
						state <= rc5_pkg::MIX;
					end else begin
						s_idx <= s_idx + 1'b1;
					end
				end
				rc5_pkg::MIX: begin
					s_tab[s_idx] <= a_new;
					s_idx        <= (s_idx == IW'(`RC5_T - 1)) ? '0 : s_idx + 1'b1;
					l_idx        <= l_idx + 1'b1;  // c is a power of two.
					step         <= step + 1'b1;
					if (step == SW'(STEPS - 1))
						state <= rc5_pkg::READY;
				end
				default: state <= state;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_load) begin
			p_val <= `RC5_P32;
			a_reg <= '0;
			b_reg <= '0;
			for (int k = 0; k < C; k++)
				l_arr[k] <= bswap(i_key[`RC5_KEY_BYTES*8-1-32*k -: 32]);  // little-endian words.
		end else if (state == rc5_pkg::INIT) begin
			p_val <= p_val + `RC5_Q32;
		end else if (state == rc5_pkg::MIX) begin
			l_arr[l_idx] <= b_new;
			a_reg        <= a_new;
			b_reg        <= b_new;
		end
	end

	always_comb begin
		for (int k = 0; k < `RC5_T; k++)
			o_skey[k*`RC5_W +: `RC5_W] = s_tab[k];
	end

	assign o_ready = (state == rc5_pkg::READY);

endmodule

//--- logic/rc5_blk_if.sv
`timescale 1ns/1ns

interface rc5_blk_if;

	logic            valid;    // a captured block is waiting.
	logic            ready;    // the core can start a block this cycle.
	logic            decrypt;  // mode that goes with the block.
	rc5_pkg::block_t data;

	modport src (
		output valid,
		output decrypt,
		output data,
		input  ready
	);

	modport dst (
		input  valid,
		input  decrypt,
		input  data,
		output ready
	);

endinterface

//--- logic/rc5_pkg.sv
`include "rc5_consts.svh"

package rc5_pkg;

	// ########################################
	// data types
	// ########################################

	typedef logic [`RC5_W-1:0]           word_t;
	typedef logic [2*`RC5_W-1:0]         block_t;  // a in the upper half, b in the lower.
	typedef logic [`RC5_KEY_BYTES*8-1:0] ukey_t;   // key byte 0 sits in the top byte.
	typedef logic [`RC5_T*`RC5_W-1:0]    skey_t;   // s[0] in the least significant word.

	// ########################################
	// state machines
	// ########################################

	typedef enum logic [1:0] {
		IDLE,
		INIT,
		MIX,
		READY
	} ks_state_t;

	// receiver and sender share one encoding space.
	typedef enum logic [2:0] {
		WAIT_REQ,
		ACKED,
		WAIT_DROP,
		EMPTY,
		REQ_HIGH,
		WAIT_ACK_LOW
	} tx_state_t;

endpackage

//--- include/rc5_consts.svh
`ifndef RC5_CONSTS_SVH
`define RC5_CONSTS_SVH

// ########################################
// RC5-32/12/16 dimensions
// ########################################

`define RC5_W          32                // word width in bits.
`define RC5_R          12                // number of full rounds.
`define RC5_T          (2 * `RC5_R + 2)  // subkey words, 26 for twelve rounds.
`define RC5_KEY_BYTES  16

// ########################################
// magic constants for the table init
// ########################################

`define RC5_P32        32'hB7E15163      // odd((e - 2) * 2^32).
`define RC5_Q32        32'h9E3779B9      // odd((phi - 1) * 2^32).

`endif
